//--- vlog.f
logic/cache_pkg.sv
logic/tag_store.sv
logic/line_store.sv
logic/cache_ctrl.sv
logic/block_memory.sv
logic/cache_top.sv
dv/cache_chk.sv
dv/cache_tb.sv

//--- dv/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
  import cache_pkg::*;

  localparam int wait_limit = 64;  // cycles, a dirty miss takes about 12
  localparam int num_words  = 1 << (addr_bits - 2);

  logic      clk;
  logic      reset;
  logic      req_valid;
  cpu_req_t  req;
  logic      req_ready;
  logic      resp_valid;
  cpu_resp_t resp;

  word_t       ref_mem [num_words];  // flat word image of memory
  tag_t        model_tag [num_sets][num_ways];
  logic        model_valid [num_sets][num_ways];
  way_t        model_lru [num_sets];
  logic [31:0] rng_state;

  cache_top UUT (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  bind cache_top cache_chk u_chk (
    .clk          (clk),
    .reset        (reset),
    .req_ready    (req_ready),
    .resp_valid   (resp_valid),
    .mem_req_valid(mem_req_valid),
    .mem_done     (mem_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  always @(negedge clk) begin
    if (UUT.u_chk.fail_count != 0) begin
      abort_run("concurrent assertion in cache_chk failed");
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_hit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // two-way lookup with one lru bit per set
  task automatic model_lookup(input addr_t addr, output logic was_hit);
    index_t idx;
    tag_t   tg;
    way_t   victim;
    idx     = addr[offset_bits +: index_bits];
    tg      = addr[addr_bits-1 -: tag_bits];
    was_hit = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      if (model_valid[idx][w] && model_tag[idx][w] == tg) begin
        was_hit        = 1'b1;
        model_lru[idx] = way_t'(1 - w);
      end
    end
    if (!was_hit) begin
      victim                   = model_lru[idx];
      model_tag[idx][victim]   = tg;
      model_valid[idx][victim] = 1'b1;
      model_lru[idx]           = ~victim;  // touched by the completing hit
    end
  endtask

  task automatic do_access(input logic write, input addr_t addr, input word_t wdata,
                           output cpu_resp_t got, output int lat);
    int n;
    @(negedge clk);
    req_valid = 1'b1;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    n = 0;
    while (!req_ready) begin
      @(negedge clk);
      n++;
      if (n > wait_limit) abort_run("timeout waiting for req_ready");
    end
    @(negedge clk);  // accepted at the edge just passed
    req_valid = 1'b0;
    lat = 1;
    while (!resp_valid) begin
      @(negedge clk);
      lat++;
      if (lat > wait_limit) abort_run("timeout waiting for resp_valid");
    end
    got = resp;
  endtask

  task automatic run_access(input logic write, input addr_t addr, input word_t wdata,
                            output cpu_resp_t got);
    logic  exp_hit;
    word_t exp_data;
    int    lat;
    int    widx;
    widx     = addr[addr_bits-1:2];
    exp_data = ref_mem[widx];
    model_lookup(addr, exp_hit);
    do_access(write, addr, wdata, got, lat);
    check_hit("resp.hit", got.hit, exp_hit);
    check_word("resp.data", got.data, exp_data);  // a write lands after its response
    if (write) begin
      ref_mem[widx] = wdata;
    end
    if (exp_hit && lat != 1) abort_run("hit response did not come one cycle after acceptance");
  endtask

  task automatic read_expect(input addr_t addr, input logic exp_hit);
    cpu_resp_t got;
    run_access(1'b0, addr, '0, got);
    check_hit("resp.hit", got.hit, exp_hit);
  endtask

  task automatic after_reset();
    cpu_resp_t got;
    @(negedge clk);
    check_ready("req_ready", req_ready, 1'b1);
    check_ready("resp_valid", resp_valid, 1'b0);
    run_access(1'b0, 12'h000, '0, got);  // cold read
    check_hit("resp.hit", got.hit, 1'b0);
    check_word("resp.data", got.data, '0);
  endtask

  task automatic write_then_read();
    cpu_resp_t got;
    run_access(1'b1, 12'h014, 32'hdeadbeef, got);
    check_hit("resp.hit", got.hit, 1'b0);
    run_access(1'b0, 12'h014, '0, got);
    check_hit("resp.hit", got.hit, 1'b1);
    check_word("resp.data", got.data, 32'hdeadbeef);
    read_expect(12'h018, 1'b1);  // same line, untouched word
  endtask

  // set 5, tags 0 1 2
  task automatic lru_eviction();
    read_expect(12'h050, 1'b0);
    read_expect(12'h0d0, 1'b0);
    read_expect(12'h050, 1'b1);
    read_expect(12'h150, 1'b0);  // B is least recent
    read_expect(12'h050, 1'b1);
    read_expect(12'h0d0, 1'b0);
  endtask

  task automatic dirty_writeback();
    cpu_resp_t got;
    run_access(1'b1, 12'h064, 32'h1234_5678, got);
    run_access(1'b1, 12'h0e8, 32'hcafe_f00d, got);
    read_expect(12'h160, 1'b0);  // pushes A out dirty
    read_expect(12'h1e0, 1'b0);  // then B
    run_access(1'b0, 12'h064, '0, got);
    check_hit("resp.hit", got.hit, 1'b0);
    check_word("resp.data", got.data, 32'h1234_5678);
    run_access(1'b0, 12'h0e8, '0, got);
    check_hit("resp.hit", got.hit, 1'b0);
    check_word("resp.data", got.data, 32'hcafe_f00d);
  endtask

  task automatic random_mix();
    cpu_resp_t   got;
    logic [31:0] r;
    addr_t       addr;
    for (int i = 0; i < 200; i++) begin
      r    = next_rand();
      addr = addr_t'({r[31:27], r[26:25], 2'b00});  // 32 lines, any word
      run_access(r[24], addr, next_rand(), got);
    end
  endtask

  initial begin
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    rng_state = 32'he573;
    for (int i = 0; i < num_words; i++) begin
      ref_mem[i] = '0;
    end
    for (int s = 0; s < num_sets; s++) begin
      model_lru[s] = 1'b0;
      for (int w = 0; w < num_ways; w++) begin
        model_valid[s][w] = 1'b0;
        model_tag[s][w]   = '0;
      end
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;
    after_reset();
    write_then_read();
    lru_eviction();
    dirty_writeback();
    random_mix();
    @(negedge clk);
    if (UUT.u_chk.fail_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run("concurrent assertions in cache_chk failed");
    end
  end

endmodule

`default_nettype wire

//--- dv/cache_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cache_chk (
  input logic clk,
  input logic reset,
  input logic req_ready,
  input logic resp_valid,
  input logic mem_req_valid,
  input logic mem_done
);
  import cache_pkg::*;

  int   fail_count = 0;  // failed assertions so far
  logic mem_busy;        // a memory request is outstanding

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_busy <= 1'b0;
    end else if (mem_req_valid) begin
      mem_busy <= 1'b1;
    end else if (mem_done) begin
      mem_busy <= 1'b0;
    end
  end

  resp_one_cycle: assert property (@(posedge clk) disable iff (reset)
    resp_valid |=> !resp_valid)
    else begin
      $error("resp_valid held longer than one cycle");
      fail_count++;
    end

  ready_resp_apart: assert property (@(posedge clk) disable iff (reset)
    !(req_ready && resp_valid))
    else begin
      $error("req_ready and resp_valid high together");
      fail_count++;
    end

  // a new request may share the cycle with the previous done
  mem_one_outstanding: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid |-> (!mem_busy || mem_done))
    else begin
      $error("memory request issued while another is outstanding");
      fail_count++;
    end

  mem_done_latency: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid |-> ##mem_latency mem_done)
    else begin
      $error("mem_done missing mem_latency cycles after the request");
      fail_count++;
    end

  mem_done_source: assert property (@(posedge clk) disable iff (reset)
    mem_done |-> $past(mem_req_valid, mem_latency))
    else begin
      $error("mem_done without a request mem_latency cycles earlier");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- logic/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  cache_pkg::cpu_req_t  req,
  output logic                 req_ready,
  output logic                 resp_valid,
  output cache_pkg::cpu_resp_t resp
);
  import cache_pkg::*;

  tag_t      lookup_tag;
  index_t    lookup_index;
  word_sel_t word_sel;
  logic      hit;
  way_t      hit_way;
  way_t      victim_way;
  logic      victim_dirty;
  tag_t      victim_tag;
  logic      touch;
  logic      mark_dirty;
  logic      fill;
  way_t      act_way;
  word_t     wr_word;
  word_t     rd_word;
  line_t     victim_line;
  logic      mem_req_valid;
  mem_req_t  mem_req;
  logic      mem_done;
  line_t     mem_rdata;

  cache_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .req_valid    (req_valid),
    .req          (req),
    .req_ready    (req_ready),
    .resp_valid   (resp_valid),
    .resp         (resp),
    .lookup_tag   (lookup_tag),
    .lookup_index (lookup_index),
    .word_sel     (word_sel),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .touch        (touch),
    .mark_dirty   (mark_dirty),
    .fill         (fill),
    .act_way      (act_way),
    .wr_word      (wr_word),
    .rd_word      (rd_word),
    .victim_line  (victim_line),
    .mem_req_valid(mem_req_valid),
    .mem_req      (mem_req),
    .mem_done     (mem_done),
    .mem_rdata    (mem_rdata)
  );

  tag_store u_tags (
    .clk          (clk),
    .reset        (reset),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .touch        (touch),
    .mark_dirty   (mark_dirty),
    .fill         (fill),
    .act_way      (act_way),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  // word write shares the dirty strobe
  line_store u_lines (
    .clk         (clk),
    .reset       (reset),
    .index       (lookup_index),
    .word_sel    (word_sel),
    .way         (act_way),
    .word_we     (mark_dirty),
    .wr_word     (wr_word),
    .fill        (fill),
    .fill_line   (mem_rdata),
    .rd_word     (rd_word),
    .victim_line (victim_line)
  );

  block_memory u_mem (
    .clk          (clk),
    .reset        (reset),
    .mem_req_valid(mem_req_valid),
    .mem_req      (mem_req),
    .mem_done     (mem_done),
    .mem_rdata    (mem_rdata)
  );

endmodule

`default_nettype wire

//--- logic/block_memory.sv
`timescale 1ns/1ps
`default_nettype none

module block_memory (
  input  logic                clk,
  input  logic                reset,
  input  logic                mem_req_valid,
  input  cache_pkg::mem_req_t mem_req,
  output logic                mem_done,
  output cache_pkg::line_t    mem_rdata
);
  import cache_pkg::*;

  line_t    mem [mem_lines];
  mem_req_t req_q;  // request being served
  logic     busy;
  logic     [$clog2(mem_latency)-1:0] count;
  logic     start;
  logic     finish;

  assign start  = mem_req_valid && !busy;
  // done is registered here so it shows up mem_latency edges after the request
  assign finish = busy && (count == 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      count    <= '0;
      mem_done <= 1'b0;
      for (int i = 0; i < mem_lines; i++) begin
        mem[i] <= '0;
      end
    end else begin
      mem_done <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= $bits(count)'(mem_latency - 1);
      end else if (busy) begin
        count <= count - 1'b1;
        if (finish) begin
          busy     <= 1'b0;
          mem_done <= 1'b1;
          if (req_q.write) begin
            mem[req_q.addr] <= req_q.line;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req_q <= mem_req;
    end
    if (finish && !req_q.write) begin
      mem_rdata <= mem[req_q.addr];  // valid with mem_done
    end
  end

endmodule

`default_nettype wire

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  cache_pkg::cpu_req_t  req,
  output logic                 req_ready,
  output logic                 resp_valid,
  output cache_pkg::cpu_resp_t resp,
  output cache_pkg::tag_t      lookup_tag,
  output cache_pkg::index_t    lookup_index,
  output cache_pkg::word_sel_t word_sel,
  input  logic                 hit,
  input  cache_pkg::way_t      hit_way,
  input  cache_pkg::way_t      victim_way,
  input  logic                 victim_dirty,
  input  cache_pkg::tag_t      victim_tag,
  output logic                 touch,
  output logic                 mark_dirty,
  output logic                 fill,
  output cache_pkg::way_t      act_way,
  output cache_pkg::word_t     wr_word,
  input  cache_pkg::word_t     rd_word,
  input  cache_pkg::line_t     victim_line,
  output logic                 mem_req_valid,
  output cache_pkg::mem_req_t  mem_req,
  input  logic                 mem_done,
  input  cache_pkg::line_t     mem_rdata
);
  import cache_pkg::*;

  cache_state_e state;
  cache_state_e state_next;
  cpu_req_t     req_q;      // accepted request
  logic         miss_seen;  // this request went to memory
  logic         accept;

  assign accept = req_valid && req_ready;

  // address fields of the held request
  assign lookup_tag   = req_q.addr[addr_bits-1 -: tag_bits];
  assign lookup_index = req_q.addr[offset_bits +: index_bits];
  assign word_sel     = req_q.addr[offset_bits-1 -: $bits(word_sel_t)];
  assign wr_word      = req_q.wdata;

  assign req_ready  = (state == idle);
  assign resp_valid = (state == compare_tag) && hit;  // completing hit

  always_comb begin
    resp.hit  = !miss_seen;
    resp.data = rd_word;
  end

  assign touch      = resp_valid;
  assign mark_dirty = resp_valid && req_q.write;  // word write rides along
  assign fill       = (state == allocate) && mem_done;
  assign act_way    = resp_valid ? hit_way : victim_way;

  always_comb begin
    state_next    = state;
    mem_req_valid = 1'b0;
    mem_req.write = 1'b0;
    mem_req.addr  = {lookup_tag, lookup_index};  // fetch of the requested line
    mem_req.line  = '0;
    case (state)
      idle: begin
        if (req_valid) begin
          state_next = compare_tag;
        end
      end
      compare_tag: begin
        if (hit) begin
          state_next = idle;
        end else if (victim_dirty) begin
          // evict first
          mem_req_valid = 1'b1;
          mem_req.write = 1'b1;
          mem_req.addr  = {victim_tag, lookup_index};
          mem_req.line  = victim_line;
          state_next    = writeback;
        end else begin
          mem_req_valid = 1'b1;
          state_next    = allocate;
        end
      end
      writeback: begin
        if (mem_done) begin
          mem_req_valid = 1'b1;  // read follows the write at once
          state_next    = allocate;
        end
      end
      allocate: begin
        if (mem_done) begin
          state_next = compare_tag;  // retry lookup on the filled line
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      miss_seen <= 1'b0;
    end else begin
      state <= state_next;
      if (accept) begin
        miss_seen <= 1'b0;
      end else if ((state == compare_tag) && !hit) begin
        miss_seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
  end

endmodule

`default_nettype wire

//--- logic/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store (
  input  logic                 clk,
  input  logic                 reset,
  input  cache_pkg::index_t    index,
  input  cache_pkg::word_sel_t word_sel,
  input  cache_pkg::way_t      way,
  input  logic                 word_we,
  input  cache_pkg::word_t     wr_word,
  input  logic                 fill,
  input  cache_pkg::line_t     fill_line,
  output cache_pkg::word_t     rd_word,
  output cache_pkg::line_t     victim_line
);
  import cache_pkg::*;

  line_t lines [num_sets][num_ways];
  line_t sel_line;

  assign sel_line = lines[index][way];

  // word lane out of the addressed line
  assign rd_word     = sel_line[word_sel*$bits(word_t) +: $bits(word_t)];
  assign victim_line = sel_line;  // whole line for writeback

  // no writes land while reset is held
  always_ff @(posedge clk) begin
    if (!reset) begin
      if (fill) begin
        lines[index][way] <= fill_line;
      end else if (word_we) begin
        lines[index][way][word_sel*$bits(word_t) +: $bits(word_t)] <= wr_word;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store (
  input  logic              clk,
  input  logic              reset,
  input  cache_pkg::index_t lookup_index,
  input  cache_pkg::tag_t   lookup_tag,
  input  logic              touch,
  input  logic              mark_dirty,
  input  logic              fill,
  input  cache_pkg::way_t   act_way,
  output logic              hit,
  output cache_pkg::way_t   hit_way,
  output cache_pkg::way_t   victim_way,
  output logic              victim_dirty,
  output cache_pkg::tag_t   victim_tag
);
  import cache_pkg::*;

  tag_t tags  [num_sets][num_ways];
  logic valid [num_sets][num_ways];
  logic dirty [num_sets][num_ways];
  way_t lru   [num_sets];  // way to replace next

  logic hit0;
  logic hit1;

  // both ways compared in parallel
  assign hit0 = valid[lookup_index][0] && (tags[lookup_index][0] == lookup_tag);
  assign hit1 = valid[lookup_index][1] && (tags[lookup_index][1] == lookup_tag);

  assign hit     = hit0 | hit1;
  assign hit_way = hit1;  // a tag lives in at most one way

  assign victim_way   = lru[lookup_index];
  assign victim_dirty = dirty[lookup_index][victim_way];  // dirty implies valid
  assign victim_tag   = tags[lookup_index][victim_way];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        lru[s] <= 1'b0;
        for (int w = 0; w < num_ways; w++) begin
          valid[s][w] <= 1'b0;
          dirty[s][w] <= 1'b0;
        end
      end
    end else begin
      if (touch) begin
        lru[lookup_index] <= ~act_way;  // point at the other way
      end
      if (mark_dirty) begin
        dirty[lookup_index][act_way] <= 1'b1;
      end
      if (fill) begin
        valid[lookup_index][act_way] <= 1'b1;
        dirty[lookup_index][act_way] <= 1'b0;  // fresh copy of memory
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tags[lookup_index][act_way] <= lookup_tag;
    end
  end

endmodule

`default_nettype wire

//--- logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

  localparam int addr_bits   = 12;
  localparam int offset_bits = 4;  // 16 byte lines
  localparam int index_bits  = 3;
  localparam int tag_bits    = addr_bits - offset_bits - index_bits;  // 5
  localparam int num_sets    = 1 << index_bits;
  localparam int num_ways    = 2;
  localparam int mem_lines   = 256;  // whole 4 KiB space
  localparam int mem_latency = 4;    // request edge to done

  typedef logic [addr_bits-1:0]  addr_t;
  typedef logic [31:0]           word_t;
  typedef logic [127:0]          line_t;
  typedef logic [tag_bits-1:0]   tag_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [1:0]            word_sel_t;
  typedef logic [7:0]            line_addr_t;  // {tag, index}
  typedef logic                  way_t;

  // processor side
  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t wdata;
  } cpu_req_t;

  typedef struct packed {
    logic  hit;   // first lookup hit
    word_t data;
  } cpu_resp_t;

  // memory side, one line per request
  typedef struct packed {
    logic       write;
    line_addr_t addr;
    line_t      line;
  } mem_req_t;

  typedef enum logic [1:0] {
    idle,
    compare_tag,
    writeback,
    allocate
  } cache_state_e;

endpackage

`default_nettype wire
